//--- center_tap.sv
`timescale 1ns/100ps

module center_tap import ci_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   shift_en,
  input  col_t   col_pix,
  output pixel_t center
);

  pixel_t mid_pix;

  assign mid_pix = col_pix[HALF];  // Middle row of the strip.

  // HALF + 1 stages put column c - 6 at the output once column c is in.
  tap_delay #(
    .DEPTH    (HALF + 1),
    .payload_t(pixel_t)
  ) u_mid_delay (
    .clk  (clk),
    .rst_n(rst_n),
    .en   (shift_en),
    .din  (mid_pix),
    .dout (center)
  );

endmodule

//--- ci_assert.sv
`timescale 1ns/100ps

module ci_assert #(
  parameter bit CHECK_DATA = 1'b1,
  parameter int NCTRL      = 4
) (
  input logic             clk,
  input logic             rst_n,
  input logic             req,
  input logic             ack,
  input logic [1:0]       data,
  input logic [NCTRL-1:0] ctrl
);

  // Four-phase rule.
  req_held: assert property (@(posedge clk) disable iff (!rst_n)
    req && !ack |=> req)
    else $error("req withdrawn before ack");

  if (CHECK_DATA) begin : g_data
    data_stable: assert property (@(posedge clk) disable iff (!rst_n)
      req |=> !req || $stable(data))
      else $error("data changed while req high");
  end

  reset_state: assert property (@(posedge clk)
    !rst_n |=> ctrl == '0)
    else $error("control outputs not low after reset");

endmodule

bind ci_compare ci_assert #(
  .CHECK_DATA(1'b1),
  .NCTRL     (3)
) u_out_check (
  .clk  (clk),
  .rst_n(rst_n),
  .req  (out_req),
  .ack  (out_ack),
  .data ({ci, out_last}),
  .ctrl ({out_req, out_last, busy})
);

// Column data lives outside the controller.
bind ci_controller ci_assert #(
  .CHECK_DATA(1'b0),
  .NCTRL     (4)
) u_in_check (
  .clk  (clk),
  .rst_n(rst_n),
  .req  (col_req),
  .ack  (col_ack),
  .data (2'b00),
  .ctrl ({col_ack, shift_en, win_valid, win_last})
);

//--- ci_compare.sv
`timescale 1ns/100ps

module ci_compare import ci_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    win_valid,
  input  logic    win_last,
  input  pixel_t  center,
  input  winsum_t win_sum,
  output logic    out_req,
  input  logic    out_ack,
  output logic    ci,
  output logic    out_last,
  output logic    busy
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    DROP
  } state_t;

  state_t  state;
  winsum_t scaled;

  assign scaled = winsum_t'(center) * winsum_t'(CI_SCALE);
  assign busy   = state != IDLE;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= IDLE;
      out_req  <= 1'b0;
      ci       <= 1'b0;
      out_last <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          // Controller holds off new windows while busy.
          if (win_valid) begin
            ci       <= scaled >= win_sum;
            out_last <= win_last;
            out_req  <= 1'b1;
            state    <= REQ;
          end
        end
        REQ: begin
          if (out_ack) begin
            out_req <= 1'b0;
            state   <= DROP;
          end
        end
        DROP: begin
          if (!out_ack) begin
            state <= IDLE;  // Sink has released.
          end
        end
        default: begin
          out_req <= 1'b0;
          state   <= IDLE;
        end
      endcase
    end
  end

endmodule

//--- ci_controller.sv
`timescale 1ns/100ps

module ci_controller import ci_pkg::*; #(
  parameter int COLS = 16,
  parameter int ROWS = 14
) (
  input  logic clk,
  input  logic rst_n,
  input  logic col_req,
  output logic col_ack,
  input  logic busy,
  output logic shift_en,
  output logic strip_start,
  output logic win_valid,
  output logic win_last
);

  localparam int STRIPS = ROWS - WIN + 1;
  localparam int CW     = (COLS > 1) ? $clog2(COLS) : 1;
  localparam int SW     = (STRIPS > 1) ? $clog2(STRIPS) : 1;

  logic [CW-1:0] col_cnt;
  logic [SW-1:0] strip_cnt;
  logic          win_pend;   // Accepted column completes a window.
  logic          last_pend;  // Accepted column ends the frame.
  logic          col_done;
  logic          col_last;
  logic          strip_last;
  logic          accept;

  assign col_done   = col_cnt >= CW'(WIN - 1);
  assign col_last   = col_cnt == CW'(COLS - 1);
  assign strip_last = strip_cnt == SW'(STRIPS - 1);

  // A completing column waits while the comparator still holds a result.
  assign accept = col_req && !col_ack && !(col_done && (busy || win_valid));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_ack     <= 1'b0;
      shift_en    <= 1'b0;
      strip_start <= 1'b0;
      win_valid   <= 1'b0;
      win_last    <= 1'b0;
      win_pend    <= 1'b0;
      last_pend   <= 1'b0;
      col_cnt     <= '0;
      strip_cnt   <= '0;
    end else begin
      shift_en  <= accept;
      win_valid <= shift_en && win_pend;
      win_last  <= shift_en && win_pend && last_pend;

      if (accept) begin
        col_ack     <= 1'b1;
        strip_start <= col_cnt == '0;
        win_pend    <= col_done;
        last_pend   <= col_last && strip_last;
        if (col_last) begin
          col_cnt   <= '0;
          strip_cnt <= strip_last ? '0 : strip_cnt + 1'b1;  // Wrap to a new frame.
        end else begin
          col_cnt <= col_cnt + 1'b1;
        end
      end else begin
        strip_start <= 1'b0;
        if (col_ack && !col_req) begin
          col_ack <= 1'b0;  // Source has withdrawn.
        end
      end
    end
  end

endmodule

//--- ci_pkg.sv
package ci_pkg;

  // Window geometry.
  localparam int WIN      = 13;
  localparam int HALF     = (WIN - 1) / 2;
  localparam int CI_SCALE = WIN * WIN;  // Pixels per window.

  // One pixel.
  typedef logic [7:0] pixel_t;

  // Sum of one column, 13 x 255 at most.
  typedef logic [11:0] colsum_t;

  // Sum of a full window, 169 x 255 at most.
  typedef logic [15:0] winsum_t;

  // One input column; element i is row i of the strip.
  typedef pixel_t [WIN-1:0] col_t;

endpackage

//--- ci_top.sv
`timescale 1ns/100ps

module ci_top import ci_pkg::*; #(
  parameter int COLS = 16,
  parameter int ROWS = 14
) (
  input  logic clk,
  input  logic rst_n,
  input  logic col_req,
  output logic col_ack,
  input  col_t col_pix,
  output logic out_req,
  input  logic out_ack,
  output logic ci,
  output logic out_last
);

  logic    shift_en;
  logic    strip_start;
  logic    win_valid;
  logic    win_last;
  logic    busy;
  winsum_t win_sum;
  pixel_t  center;

  ci_controller #(
    .COLS(COLS),
    .ROWS(ROWS)
  ) u_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .col_req    (col_req),
    .col_ack    (col_ack),
    .busy       (busy),
    .shift_en   (shift_en),
    .strip_start(strip_start),
    .win_valid  (win_valid),
    .win_last   (win_last)
  );

  // Sum and center paths run side by side.
  window_sum u_sum (
    .clk        (clk),
    .rst_n      (rst_n),
    .shift_en   (shift_en),
    .strip_start(strip_start),
    .col_pix    (col_pix),
    .win_sum    (win_sum)
  );

  center_tap u_center (
    .clk     (clk),
    .rst_n   (rst_n),
    .shift_en(shift_en),
    .col_pix (col_pix),
    .center  (center)
  );

  ci_compare u_cmp (
    .clk      (clk),
    .rst_n    (rst_n),
    .win_valid(win_valid),
    .win_last (win_last),
    .center   (center),
    .win_sum  (win_sum),
    .out_req  (out_req),
    .out_ack  (out_ack),
    .ci       (ci),
    .out_last (out_last),
    .busy     (busy)
  );

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_ci -f sim.f

result=$(./obj_dir/Vtb_ci) || true
printf '%s\n' "$result"

if printf '%s\n' "$result" | grep -qx 'PASS: all tests'; then
  exit 0
fi
exit 1

//--- sim.f
ci_pkg.sv
tap_delay.sv
ci_controller.sv
window_sum.sv
center_tap.sv
ci_compare.sv
ci_top.sv
ci_assert.sv
tb_ci.sv

//--- tap_delay.sv
`timescale 1ns/100ps

module tap_delay #(
  parameter int  DEPTH     = 2,
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     en,
  input  payload_t din,
  output payload_t dout
);

  payload_t taps [DEPTH];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        taps[i] <= '0;
      end
    end else if (en) begin
      taps[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        taps[i] <= taps[i-1];
      end
    end
  end

  // Oldest entry, pushed DEPTH shifts ago.
  assign dout = taps[DEPTH-1];

endmodule

//--- tb_ci.sv
`timescale 1ns/100ps

module tb_ci import ci_pkg::*; ();

  localparam int COLS       = 16;
  localparam int ROWS       = 14;
  localparam int STRIPS     = ROWS - WIN + 1;
  localparam int PER_STRIP  = COLS - WIN + 1;
  localparam int PER_FRAME  = STRIPS * PER_STRIP;
  localparam int FRAME_COLS = STRIPS * COLS;
  localparam int N_FRAMES   = 15;  // Frames sent over all tests.
  localparam int MAX_CYCLES = N_FRAMES * FRAME_COLS * 12 + 4000;

  logic   clk;
  logic   rst_n;
  logic   col_req;
  logic   col_ack;
  col_t   col_pix;
  logic   out_req;
  logic   out_ack;
  logic   ci;
  logic   out_last;

  pixel_t img [ROWS][COLS];
  logic   exp_ci [$];
  logic   got_ci [$];
  logic   got_last [$];
  integer seed;
  int     ack_delay_max;
  int     errors;
  int     checks;
  int     tests;
  int     cycles;

  ci_top #(
    .COLS(COLS),
    .ROWS(ROWS)
  ) DUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .col_req (col_req),
    .col_ack (col_ack),
    .col_pix (col_pix),
    .out_req (out_req),
    .out_ack (out_ack),
    .ci      (ci),
    .out_last(out_last)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check(input string name, input string what, input int expected,
                       input int actual);
    checks++;
    if (expected != actual) begin
      errors++;
      $display("[FAIL] %s %s: expected %0d, actual %0d", name, what, expected, actual);
    end
  endtask

  task automatic apply_reset(input int cycles_low);
    @(posedge clk);
    rst_n   <= 1'b0;
    col_req <= 1'b0;
    out_ack <= 1'b0;
    repeat (cycles_low) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic fill_image(input pixel_t value);
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        img[r][c] = value;
      end
    end
  endtask

  task automatic fill_random();
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < COLS; c++) begin
        img[r][c] = pixel_t'($random(seed));
      end
    end
  endtask

  // Window of strip s ending at column c; center is 6 rows down, 6 columns back.
  function automatic logic window_bit(input int s, input int c);
    int sum;
    int ctr;
    sum = 0;
    for (int r = s; r < s + WIN; r++) begin
      for (int k = c - WIN + 1; k <= c; k++) begin
        sum += int'(img[r][k]);
      end
    end
    ctr = int'(img[s + HALF][c - HALF]);
    return ctr * CI_SCALE >= sum;
  endfunction

  task automatic model_frame();
    for (int s = 0; s < STRIPS; s++) begin
      for (int c = WIN - 1; c < COLS; c++) begin
        exp_ci.push_back(window_bit(s, c));
      end
    end
  endtask

  // Drives one column and returns once col_ack is seen, col_req still high.
  task automatic offer_column(input int s, input int c);
    col_t pix;
    for (int i = 0; i < WIN; i++) begin
      pix[i] = img[s + i][c];  // Row i of the strip.
    end
    col_pix <= pix;
    col_req <= 1'b1;
    @(posedge clk);
    while (!col_ack) @(posedge clk);
  endtask

  task automatic send_column(input int s, input int c);
    offer_column(s, c);
    col_req <= 1'b0;
    @(posedge clk);
    while (col_ack) @(posedge clk);
  endtask

  task automatic send_frame();
    for (int s = 0; s < STRIPS; s++) begin
      for (int c = 0; c < COLS; c++) begin
        send_column(s, c);
      end
    end
  endtask

  task automatic collect_results(input int n);
    int delay;
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      while (!out_req) @(posedge clk);
      got_ci.push_back(ci);
      got_last.push_back(out_last);
      delay = 0;
      if (ack_delay_max > 0) begin
        delay = {$random(seed)} % (ack_delay_max + 1);
      end
      repeat (delay) @(posedge clk);
      out_ack <= 1'b1;
      @(posedge clk);
      while (out_req) @(posedge clk);
      out_ack <= 1'b0;
    end
  endtask

  // Sends the image nframes times and checks every result against the model.
  task automatic run_frames(input string name, input int nframes);
    int n;
    exp_ci.delete();
    got_ci.delete();
    got_last.delete();
    for (int f = 0; f < nframes; f++) begin
      model_frame();
    end
    n = nframes * PER_FRAME;
    fork
      for (int f = 0; f < nframes; f++) begin
        send_frame();
      end
      collect_results(n);
    join
    repeat (8) @(posedge clk);
    check(name, "extra out_req", 0, int'(out_req));
    for (int k = 0; k < n; k++) begin
      check(name, $sformatf("result %0d ci", k), int'(exp_ci[k]), int'(got_ci[k]));
      check(name, $sformatf("result %0d out_last", k),
            int'((k % PER_FRAME) == PER_FRAME - 1), int'(got_last[k]));
    end
  endtask

  task automatic end_test(input string name, input int err0);
    tests++;
    $display("Test %s finished with %0d errors", name, errors - err0);
  endtask

  task automatic test_uniform();
    int err0;
    err0 = errors;
    fill_image(8'd77);
    run_frames("uniform", 1);
    for (int k = 0; k < PER_FRAME; k++) begin
      check("uniform", $sformatf("result %0d", k), 1, int'(got_ci[k]));
    end
    end_test("uniform", err0);
  endtask

  task automatic test_dark_center();
    int err0;
    int s;
    int c;
    err0 = errors;
    for (int k = 0; k < PER_FRAME; k++) begin
      s = k / PER_STRIP;
      c = WIN - 1 + k % PER_STRIP;
      fill_image(8'd200);
      img[s + HALF][c - HALF] = 8'd10;  // Center of window k only.
      run_frames("dark_center", 1);
      for (int j = 0; j < PER_FRAME; j++) begin
        check("dark_center", $sformatf("frame %0d result %0d", k, j),
              int'(j != k), int'(got_ci[j]));
      end
    end
    end_test("dark_center", err0);
  endtask

  task automatic test_random();
    int err0;
    err0 = errors;
    fill_random();
    run_frames("random", 1);
    end_test("random", err0);
  endtask

  task automatic test_back_pressure();
    int err0;
    err0 = errors;
    fill_random();
    ack_delay_max = 20;
    run_frames("back_pressure", 1);
    ack_delay_max = 0;
    end_test("back_pressure", err0);
  endtask

  task automatic test_framing();
    int err0;
    err0 = errors;
    fill_random();
    run_frames("framing", 2);
    end_test("framing", err0);
  endtask

  task automatic test_reset_mid_frame();
    int err0;
    err0 = errors;
    fill_random();
    for (int c = 0; c < WIN - 1; c++) begin
      send_column(0, c);
    end
    offer_column(0, WIN - 1);  // Left with col_ack high.
    while (!out_req) @(posedge clk);  // First window pending, never acked.
    apply_reset(16);
    @(posedge clk);
    check("reset_mid_frame", "out_req after reset", 0, int'(out_req));
    check("reset_mid_frame", "col_ack after reset", 0, int'(col_ack));
    fill_random();
    run_frames("reset_mid_frame", 1);
    end_test("reset_mid_frame", err0);
  endtask

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    rst_n         <= 1'b0;
    col_req       <= 1'b0;
    col_pix       <= '0;
    out_ack       <= 1'b0;
    seed          = 32'hcae6_9f96;
    ack_delay_max = 0;
    errors        = 0;
    checks        = 0;
    tests         = 0;
    apply_reset(16);
    test_uniform();
    test_dark_center();
    test_random();
    test_back_pressure();
    test_framing();
    test_reset_mid_frame();
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- window_sum.sv
`timescale 1ns/100ps

module window_sum import ci_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  input  logic    shift_en,
  input  logic    strip_start,
  input  col_t    col_pix,
  output winsum_t win_sum
);

  localparam int FW = $clog2(WIN + 1);

  colsum_t       col_sum;
  colsum_t       col_old;
  colsum_t       departing;
  logic [FW-1:0] fill;  // Columns of the strip already summed.

  // Adder over the 13 rows.
  always_comb begin
    colsum_t acc;
    acc = '0;
    for (int i = 0; i < WIN; i++) begin
      acc = acc + colsum_t'(col_pix[i]);
    end
    col_sum = acc;
  end

  tap_delay #(
    .DEPTH    (WIN),
    .payload_t(colsum_t)
  ) u_col_delay (
    .clk  (clk),
    .rst_n(rst_n),
    .en   (shift_en),
    .din  (col_sum),
    .dout (col_old)
  );

  // Nothing leaves until the window is full.
  assign departing = (fill < FW'(WIN)) ? '0 : col_old;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_sum <= '0;
      fill    <= '0;
    end else if (shift_en) begin
      if (strip_start) begin
        win_sum <= winsum_t'(col_sum);
        fill    <= FW'(1);
      end else begin
        win_sum <= win_sum + winsum_t'(col_sum) - winsum_t'(departing);
        if (fill < FW'(WIN)) begin
          fill <= fill + 1'b1;
        end
      end
    end
  end

endmodule
